// ==== src/net_iso_pkg.sv ====
`default_nettype none

package net_iso_pkg;

    // AXI-Lite control bus, one word wide
    localparam int CTRL_ADDR_WIDTH = 32;
    localparam int CTRL_DATA_WIDTH = 32;

    // Byte addresses of the two mapped registers
    localparam logic [CTRL_ADDR_WIDTH-1:0] DECOUPLE_REG_ADDR = 32'h0000_0000;
    localparam logic [CTRL_ADDR_WIDTH-1:0] VERIFIER_REG_ADDR = 32'h0000_0004;

    // Register 0, decoupler control and status
    localparam int DECOUPLE_BIT         = 0;
    localparam int DECOUPLE_DONE_BIT    = 1;
    localparam int DECOUPLED_STATUS_BIT = 2;

    // Register 4, oversize verifier
    localparam int OVERSIZE_CLEAR_BIT   = 0;
    localparam int OVERSIZE_IRQ_BIT     = 2;

    // AXI response codes in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // Egress decoupler states
    typedef enum logic [1:0] {
        ST_PASS      = 2'b00,
        ST_DRAIN     = 2'b01,
        ST_DECOUPLED = 2'b10
    } decoupler_state_e;

endpackage

`default_nettype wire

// ==== src/tx_decoupler.sv ====
`default_nettype none

module tx_decoupler #(
    parameter int DATA_WIDTH = 64,
    parameter int DEST_WIDTH = 4
) (
    input  wire                      aclk,
    input  wire                      arst_n,

    // Upstream
    input  wire [DATA_WIDTH-1:0]     s_tdata,
    input  wire [DEST_WIDTH-1:0]     s_tdest,
    input  wire [DATA_WIDTH/8-1:0]   s_tkeep,
    input  wire                      s_tlast,
    input  wire                      s_tvalid,
    output logic                     s_tready,

    // Downstream
    output logic [DATA_WIDTH-1:0]    m_tdata,
    output logic [DEST_WIDTH-1:0]    m_tdest,
    output logic [DATA_WIDTH/8-1:0]  m_tkeep,
    output logic                     m_tlast,
    output logic                     m_tvalid,
    input  wire                      m_tready,

    // Control
    input  wire                      decouple,
    input  wire                      oversize_irq,
    input  wire                      tlast_forced,
    output logic                     decouple_done,
    output logic                     decoupled
);

    import net_iso_pkg::*;

    decoupler_state_e state;
    decoupler_state_e state_nxt;
    logic             in_packet;
    logic             in_packet_nxt;
    logic             s_xfer;
    logic             m_xfer;
    logic             req;

    // Payload is untouched, only the handshake is gated
    assign m_tdata  = s_tdata;
    assign m_tdest  = s_tdest;
    assign m_tkeep  = s_tkeep;
    assign m_tlast  = s_tlast;

    // Decoupled: nothing goes down, upstream beats are swallowed
    assign m_tvalid = s_tvalid && (state != ST_DECOUPLED);
    assign s_tready = (state == ST_DECOUPLED) ? 1'b1 : m_tready;

    assign s_xfer = s_tvalid && s_tready;
    assign m_xfer = m_tvalid && m_tready;
    assign req    = decouple || oversize_irq;

    // Upstream packet framing, discarded beats counted too
    assign in_packet_nxt = s_xfer ? !s_tlast : in_packet;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_PASS: begin
                // Forced tlast, the error latches on the next cycle
                if (m_xfer && tlast_forced) begin
                    state_nxt = ST_DECOUPLED;
                end else if (req) begin
                    state_nxt = in_packet_nxt ? ST_DRAIN : ST_DECOUPLED;
                end
            end
            ST_DRAIN: begin
                // Let the open packet finish first
                if (m_xfer && (s_tlast || tlast_forced)) begin
                    state_nxt = ST_DECOUPLED;
                end
            end
            ST_DECOUPLED: begin
                // Only rejoin between packets
                if (!req && !in_packet_nxt) begin
                    state_nxt = ST_PASS;
                end
            end
            default: state_nxt = ST_PASS;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_PASS;
            in_packet <= 1'b0;
        end else begin
            state     <= state_nxt;
            in_packet <= in_packet_nxt;
        end
    end

    assign decoupled     = (state == ST_DECOUPLED);
    assign decouple_done = decoupled && decouple;

endmodule

`default_nettype wire

// ==== src/tx_oversize_verifier.sv ====
`default_nettype none

module tx_oversize_verifier #(
    parameter int DATA_WIDTH       = 64,
    parameter int DEST_WIDTH       = 4,
    parameter int MAX_PACKET_BEATS = 191
) (
    input  wire                      aclk,
    input  wire                      arst_n,

    // Upstream
    input  wire [DATA_WIDTH-1:0]     s_tdata,
    input  wire [DEST_WIDTH-1:0]     s_tdest,
    input  wire [DATA_WIDTH/8-1:0]   s_tkeep,
    input  wire                      s_tlast,
    input  wire                      s_tvalid,
    output logic                     s_tready,

    // Downstream
    output logic [DATA_WIDTH-1:0]    m_tdata,
    output logic [DEST_WIDTH-1:0]    m_tdest,
    output logic [DATA_WIDTH/8-1:0]  m_tkeep,
    output logic                     m_tlast,
    output logic                     m_tvalid,
    input  wire                      m_tready,

    // Control
    input  wire                      oversize_clear,
    output logic                     oversize_irq,
    output logic                     tlast_forced
);

    localparam int CNT_WIDTH = $clog2(MAX_PACKET_BEATS + 1);

    // Beats already sent in the current packet
    logic [CNT_WIDTH-1:0] beat_cnt;
    logic                 at_limit;
    logic                 xfer;

    // Zero latency, handshake passes straight through
    assign m_tdata  = s_tdata;
    assign m_tdest  = s_tdest;
    assign m_tkeep  = s_tkeep;
    assign m_tvalid = s_tvalid;
    assign s_tready = m_tready;

    assign xfer     = s_tvalid && s_tready;

    // Current beat is the last one allowed
    assign at_limit = (beat_cnt == CNT_WIDTH'(MAX_PACKET_BEATS - 1));

    // Truncate by forcing tlast on the limit beat
    assign m_tlast      = s_tlast || at_limit;
    assign tlast_forced = s_tvalid && at_limit && !s_tlast;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt <= '0;
        end else if (xfer) begin
            // Restart after any tlast sent, real or forced
            beat_cnt <= m_tlast ? '0 : beat_cnt + 1'b1;
        end
    end

    // Sticky error, a new violation wins over the clear
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            oversize_irq <= 1'b0;
        end else if (xfer && tlast_forced) begin
            oversize_irq <= 1'b1;
        end else if (oversize_clear) begin
            oversize_irq <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/reg_slice_full.sv ====
`default_nettype none

module reg_slice_full #(
    parameter int WIDTH = 32
) (
    input  wire              aclk,
    input  wire              arst_n,

    // Input side
    input  wire [WIDTH-1:0]  in_data,
    input  wire              in_valid,
    output logic             in_ready,

    // Output side
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  wire              out_ready
);

    // Second entry, holds the beat caught while the output stalls
    logic [WIDTH-1:0] skid_data;

    // Ready low means the skid entry is full
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
        end else if (in_ready) begin
            if (in_valid) begin
                out_valid <= 1'b1;
                // Main busy and stalled, beat lands in skid
                if (out_valid && !out_ready) begin
                    in_ready <= 1'b0;
                end
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end else if (out_ready) begin
            // Skid refills main, valid stays high
            in_ready <= 1'b1;
        end
    end

    // Payload path
    always_ff @(posedge aclk) begin
        if (in_ready && in_valid) begin
            if (!out_valid || out_ready) begin
                out_data <= in_data;
            end else begin
                skid_data <= in_data;
            end
        end else if (!in_ready && out_ready) begin
            out_data <= skid_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/net_iso_reg_file.sv ====
`default_nettype none

module net_iso_reg_file (
    input  wire                                   aclk,
    input  wire                                   arst_n,

    // Write address and data
    input  wire [net_iso_pkg::CTRL_ADDR_WIDTH-1:0] awaddr,
    input  wire                                   awvalid,
    output logic                                  awready,
    input  wire [net_iso_pkg::CTRL_DATA_WIDTH-1:0] wdata,
    input  wire                                   wvalid,
    output logic                                  wready,

    // Write response
    output net_iso_pkg::axi_resp_e                bresp,
    output logic                                  bvalid,
    input  wire                                   bready,

    // Read address and data
    input  wire [net_iso_pkg::CTRL_ADDR_WIDTH-1:0] araddr,
    input  wire                                   arvalid,
    output logic                                  arready,
    output logic [net_iso_pkg::CTRL_DATA_WIDTH-1:0] rdata,
    output net_iso_pkg::axi_resp_e                rresp,
    output logic                                  rvalid,
    input  wire                                   rready,

    // Live status
    input  wire                                   decouple_done,
    input  wire                                   decoupled,
    input  wire                                   oversize_irq,

    // Stored controls
    output logic                                  decouple,
    output logic                                  oversize_clear
);

    import net_iso_pkg::*;

    // Write sequence, high while the response is pending
    logic                       wr_resp;
    logic                       wr_hs;
    logic                       wr_ok;
    // Read sequence, high while read data is pending
    logic                       rd_resp;
    logic                       rd_hs;
    logic                       rd_ok;
    logic [CTRL_DATA_WIDTH-1:0] rd_word;

    assign wr_hs  = awready && awvalid && wvalid;
    assign rd_hs  = arready && arvalid;
    assign wr_ok  = (awaddr == DECOUPLE_REG_ADDR) || (awaddr == VERIFIER_REG_ADDR);
    assign bvalid = wr_resp;
    assign rvalid = rd_resp;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            awready        <= 1'b0;
            wready         <= 1'b0;
            wr_resp        <= 1'b0;
            decouple       <= 1'b0;
            oversize_clear <= 1'b0;
        end else begin
            // Address and data ready pulse together for one cycle
            awready <= !wr_resp && !awready && awvalid && wvalid;
            wready  <= !wr_resp && !awready && awvalid && wvalid;
            if (wr_hs) begin
                wr_resp <= 1'b1;
                // Only the writable bits, status bits ignore writes
                if (awaddr == DECOUPLE_REG_ADDR) begin
                    decouple <= wdata[DECOUPLE_BIT];
                end
                if (awaddr == VERIFIER_REG_ADDR) begin
                    oversize_clear <= wdata[OVERSIZE_CLEAR_BIT];
                end
            end else if (wr_resp && bready) begin
                wr_resp <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_hs) begin
            bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Read word, stored bits with live status merged in
    always_comb begin
        rd_word = '0;
        rd_ok   = 1'b1;
        case (araddr)
            DECOUPLE_REG_ADDR: begin
                rd_word[DECOUPLE_BIT]         = decouple;
                rd_word[DECOUPLE_DONE_BIT]    = decouple_done;
                rd_word[DECOUPLED_STATUS_BIT] = decoupled;
            end
            VERIFIER_REG_ADDR: begin
                rd_word[OVERSIZE_CLEAR_BIT] = oversize_clear;
                rd_word[OVERSIZE_IRQ_BIT]   = oversize_irq;
            end
            default: rd_ok = 1'b0;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rd_resp <= 1'b0;
        end else begin
            arready <= !rd_resp && !arready && arvalid;
            if (rd_hs) begin
                rd_resp <= 1'b1;
            end else if (rd_resp && rready) begin
                rd_resp <= 1'b0;
            end
        end
    end

    // Unmapped reads give zero data and an error
    always_ff @(posedge aclk) begin
        if (rd_hs) begin
            rdata <= rd_word;
            rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// ==== src/net_iso_top.sv ====
`default_nettype none

module net_iso_top #(
    parameter int DATA_WIDTH       = 64,
    parameter int DEST_WIDTH       = 4,
    parameter int MAX_PACKET_BEATS = 191
) (
    input  wire                                     aclk,
    input  wire                                     arst_n,

    // Egress input
    input  wire [DATA_WIDTH-1:0]                    tx_s_tdata,
    input  wire [DEST_WIDTH-1:0]                    tx_s_tdest,
    input  wire [DATA_WIDTH/8-1:0]                  tx_s_tkeep,
    input  wire                                     tx_s_tlast,
    input  wire                                     tx_s_tvalid,
    output logic                                    tx_s_tready,

    // Egress output
    output logic [DATA_WIDTH-1:0]                   tx_m_tdata,
    output logic [DEST_WIDTH-1:0]                   tx_m_tdest,
    output logic [DATA_WIDTH/8-1:0]                 tx_m_tkeep,
    output logic                                    tx_m_tlast,
    output logic                                    tx_m_tvalid,
    input  wire                                     tx_m_tready,

    // AXI-Lite control
    input  wire [net_iso_pkg::CTRL_ADDR_WIDTH-1:0]  ctrl_awaddr,
    input  wire                                     ctrl_awvalid,
    output logic                                    ctrl_awready,
    input  wire [net_iso_pkg::CTRL_DATA_WIDTH-1:0]  ctrl_wdata,
    input  wire                                     ctrl_wvalid,
    output logic                                    ctrl_wready,
    output net_iso_pkg::axi_resp_e                  ctrl_bresp,
    output logic                                    ctrl_bvalid,
    input  wire                                     ctrl_bready,
    input  wire [net_iso_pkg::CTRL_ADDR_WIDTH-1:0]  ctrl_araddr,
    input  wire                                     ctrl_arvalid,
    output logic                                    ctrl_arready,
    output logic [net_iso_pkg::CTRL_DATA_WIDTH-1:0] ctrl_rdata,
    output net_iso_pkg::axi_resp_e                  ctrl_rresp,
    output logic                                    ctrl_rvalid,
    input  wire                                     ctrl_rready
);

    // Packed beat through the output slice: data, dest, keep, last
    localparam int SLICE_WIDTH = DATA_WIDTH + DEST_WIDTH + DATA_WIDTH / 8 + 1;

    // Decoupler to verifier
    logic [DATA_WIDTH-1:0]   dec_tdata;
    logic [DEST_WIDTH-1:0]   dec_tdest;
    logic [DATA_WIDTH/8-1:0] dec_tkeep;
    logic                    dec_tlast;
    logic                    dec_tvalid;
    logic                    dec_tready;

    // Verifier to slice
    logic [DATA_WIDTH-1:0]   ver_tdata;
    logic [DEST_WIDTH-1:0]   ver_tdest;
    logic [DATA_WIDTH/8-1:0] ver_tkeep;
    logic                    ver_tlast;
    logic                    ver_tvalid;
    logic                    ver_tready;

    // Control and status between the blocks
    logic decouple;
    logic decouple_done;
    logic decoupled;
    logic oversize_irq;
    logic oversize_clear;
    logic tlast_forced;

    tx_decoupler #(
        .DATA_WIDTH (DATA_WIDTH),
        .DEST_WIDTH (DEST_WIDTH)
    ) u_decoupler (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .s_tdata       (tx_s_tdata),
        .s_tdest       (tx_s_tdest),
        .s_tkeep       (tx_s_tkeep),
        .s_tlast       (tx_s_tlast),
        .s_tvalid      (tx_s_tvalid),
        .s_tready      (tx_s_tready),
        .m_tdata       (dec_tdata),
        .m_tdest       (dec_tdest),
        .m_tkeep       (dec_tkeep),
        .m_tlast       (dec_tlast),
        .m_tvalid      (dec_tvalid),
        .m_tready      (dec_tready),
        .decouple      (decouple),
        .oversize_irq  (oversize_irq),
        .tlast_forced  (tlast_forced),
        .decouple_done (decouple_done),
        .decoupled     (decoupled)
    );

    tx_oversize_verifier #(
        .DATA_WIDTH       (DATA_WIDTH),
        .DEST_WIDTH       (DEST_WIDTH),
        .MAX_PACKET_BEATS (MAX_PACKET_BEATS)
    ) u_verifier (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .s_tdata        (dec_tdata),
        .s_tdest        (dec_tdest),
        .s_tkeep        (dec_tkeep),
        .s_tlast        (dec_tlast),
        .s_tvalid       (dec_tvalid),
        .s_tready       (dec_tready),
        .m_tdata        (ver_tdata),
        .m_tdest        (ver_tdest),
        .m_tkeep        (ver_tkeep),
        .m_tlast        (ver_tlast),
        .m_tvalid       (ver_tvalid),
        .m_tready       (ver_tready),
        .oversize_clear (oversize_clear),
        .oversize_irq   (oversize_irq),
        .tlast_forced   (tlast_forced)
    );

    // Registered output stage
    reg_slice_full #(
        .WIDTH (SLICE_WIDTH)
    ) u_slice (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .in_data   ({ver_tdata, ver_tdest, ver_tkeep, ver_tlast}),
        .in_valid  (ver_tvalid),
        .in_ready  (ver_tready),
        .out_data  ({tx_m_tdata, tx_m_tdest, tx_m_tkeep, tx_m_tlast}),
        .out_valid (tx_m_tvalid),
        .out_ready (tx_m_tready)
    );

    net_iso_reg_file u_reg_file (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .awaddr         (ctrl_awaddr),
        .awvalid        (ctrl_awvalid),
        .awready        (ctrl_awready),
        .wdata          (ctrl_wdata),
        .wvalid         (ctrl_wvalid),
        .wready         (ctrl_wready),
        .bresp          (ctrl_bresp),
        .bvalid         (ctrl_bvalid),
        .bready         (ctrl_bready),
        .araddr         (ctrl_araddr),
        .arvalid        (ctrl_arvalid),
        .arready        (ctrl_arready),
        .rdata          (ctrl_rdata),
        .rresp          (ctrl_rresp),
        .rvalid         (ctrl_rvalid),
        .rready         (ctrl_rready),
        .decouple_done  (decouple_done),
        .decoupled      (decoupled),
        .oversize_irq   (oversize_irq),
        .decouple       (decouple),
        .oversize_clear (oversize_clear)
    );

endmodule

`default_nettype wire

// ==== verification/net_iso_assert.sv ====
`default_nettype none

module net_iso_assert (
    input wire        aclk,
    input wire        arst_n,
    // Egress output of the chain
    input wire [63:0] tx_m_tdata,
    input wire [3:0]  tx_m_tdest,
    input wire [7:0]  tx_m_tkeep,
    input wire        tx_m_tlast,
    input wire        tx_m_tvalid,
    input wire        tx_m_tready,
    // Decoupler output, its handshake and state flag
    input wire        decoupled,
    input wire        dec_tvalid,
    input wire        dec_tready,
    // Verifier tlast, real or forced
    input wire        ver_tlast,
    // AXI-Lite write response
    input wire        bvalid,
    input wire        bready
);

    timeunit 1ns;
    timeprecision 100ps;

    // Packet open downstream of the decoupler
    logic dec_open;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            dec_open <= 1'b0;
        end else if (dec_tvalid && dec_tready) begin
            dec_open <= !ver_tlast;
        end
    end

    // Stalled output keeps its beat
    a_out_stable: assert property (@(posedge aclk) disable iff (!arst_n)
        (tx_m_tvalid && !tx_m_tready) |=> (tx_m_tvalid && $stable(tx_m_tdata)
            && $stable(tx_m_tdest) && $stable(tx_m_tkeep) && $stable(tx_m_tlast)))
        else $error("egress output changed while stalled");

    // Cut only lands between packets
    a_cut_at_boundary: assert property (@(posedge aclk) disable iff (!arst_n)
        $rose(decoupled) |-> !dec_open)
        else $error("decoupler cut the stream inside a packet");

    // Write response held until taken
    a_bvalid_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        (bvalid && !bready) |=> bvalid)
        else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

// ==== verification/net_iso_tb.sv ====
`default_nettype none

module net_iso_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import net_iso_pkg::*;

    localparam int MAX_BEATS = 8;
    localparam int LIMIT     = 2000;

    typedef struct packed {
        logic [63:0] data;
        logic [3:0]  dest;
        logic [7:0]  keep;
        logic        last;
    } beat_t;

    logic aclk;
    logic arst_n;
    logic [63:0] tx_s_tdata;
    logic [3:0]  tx_s_tdest;
    logic [7:0]  tx_s_tkeep;
    logic        tx_s_tlast;
    logic        tx_s_tvalid;
    logic        tx_s_tready;
    logic [63:0] tx_m_tdata;
    logic [3:0]  tx_m_tdest;
    logic [7:0]  tx_m_tkeep;
    logic        tx_m_tlast;
    logic        tx_m_tvalid;
    logic        tx_m_tready;
    logic [31:0] ctrl_awaddr;
    logic        ctrl_awvalid;
    logic        ctrl_awready;
    logic [31:0] ctrl_wdata;
    logic        ctrl_wvalid;
    logic        ctrl_wready;
    axi_resp_e   ctrl_bresp;
    logic        ctrl_bvalid;
    logic        ctrl_bready;
    logic [31:0] ctrl_araddr;
    logic        ctrl_arvalid;
    logic        ctrl_arready;
    logic [31:0] ctrl_rdata;
    axi_resp_e   ctrl_rresp;
    logic        ctrl_rvalid;
    logic        ctrl_rready;

    // Expected output beats, current packet under test
    beat_t       exp_q[$];
    logic [63:0] pkt_data[$];
    logic [7:0]  pkt_keep[$];
    logic [3:0]  pkt_dest;
    int          errors;
    int          checks;
    int          tests;
    logic [31:0] rd_data;
    axi_resp_e   rd_resp;

    net_iso_top #(
        .DATA_WIDTH       (64),
        .DEST_WIDTH       (4),
        .MAX_PACKET_BEATS (MAX_BEATS)
    ) dut0 (.*);

    bind net_iso_top net_iso_assert u_assert (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .tx_m_tdata  (tx_m_tdata),
        .tx_m_tdest  (tx_m_tdest),
        .tx_m_tkeep  (tx_m_tkeep),
        .tx_m_tlast  (tx_m_tlast),
        .tx_m_tvalid (tx_m_tvalid),
        .tx_m_tready (tx_m_tready),
        .decoupled   (decoupled),
        .dec_tvalid  (dec_tvalid),
        .dec_tready  (dec_tready),
        .ver_tlast   (ver_tlast),
        .bvalid      (ctrl_bvalid),
        .bready      (ctrl_bready)
    );

    always #20 aclk = ~aclk;

    // Random back-pressure, ready about three cycles in four
    always @(posedge aclk) begin
        #2;
        tx_m_tready <= ($urandom % 4) != 0;
    end

    // Expected beats for the packet in pkt_data, nothing if dropped
    function automatic void expected_beats(input bit dropped);
        int    kept;
        int    i;
        beat_t b;
        if (dropped) begin
            return;
        end
        kept = (pkt_data.size() > MAX_BEATS) ? MAX_BEATS : pkt_data.size();
        for (i = 0; i < kept; i++) begin
            b.data = pkt_data[i];
            b.dest = pkt_dest;
            b.keep = pkt_keep[i];
            b.last = (i == kept - 1);
            exp_q.push_back(b);
        end
    endfunction

    // Compare every beat that leaves tx_m
    always @(negedge aclk) begin
        beat_t got;
        beat_t exp;
        if (arst_n && tx_m_tvalid && tx_m_tready) begin
            got = '{tx_m_tdata, tx_m_tdest, tx_m_tkeep, tx_m_tlast};
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("CHECK FAILED at %0t ns: unexpected beat %h", $time, got);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp = exp_q.pop_front();
                assert (got === exp) else begin
                    $display("CHECK FAILED at %0t ns: beat %h expected %h", $time, got, exp);
                    errors++;
                end
            end
        end
    end

    task automatic abort_run(input string why);
        $display("Run aborted: %s", why);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s read %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    task automatic build_packet(input int len);
        int i;
        pkt_data.delete();
        pkt_keep.delete();
        pkt_dest = 4'($urandom);
        for (i = 0; i < len; i++) begin
            pkt_data.push_back({$urandom, $urandom});
            pkt_keep.push_back(8'($urandom));
        end
    endtask

    // Drive beats first..last of the packet, tlast on the packet end
    task automatic send_beats(input int first, input int last);
        int i;
        int n;
        for (i = first; i <= last; i++) begin
            tx_s_tdata  = pkt_data[i];
            tx_s_tdest  = pkt_dest;
            tx_s_tkeep  = pkt_keep[i];
            tx_s_tlast  = (i == pkt_data.size() - 1);
            tx_s_tvalid = 1'b1;
            n = 0;
            @(negedge aclk);
            while (!tx_s_tready) begin
                n++;
                if (n > LIMIT) abort_run("tx_s_tready never came for an input beat");
                @(negedge aclk);
            end
            @(posedge aclk);
            #2;
        end
        tx_s_tvalid = 1'b0;
        tx_s_tlast  = 1'b0;
    endtask

    task automatic send_packet(input int len, input bit dropped);
        build_packet(len);
        expected_beats(dropped);
        send_beats(0, len - 1);
    endtask

    // Output idle for a few cycles with nothing left to expect
    task automatic wait_drained();
        int idle;
        int n;
        idle = 0;
        n = 0;
        while (idle < 4) begin
            @(negedge aclk);
            n++;
            if (exp_q.size() == 0 && !tx_m_tvalid) idle++;
            else idle = 0;
            if (n > LIMIT) abort_run("egress output did not drain in time");
        end
        @(posedge aclk);
        #2;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input axi_resp_e exp_resp);
        int n;
        ctrl_awaddr  = addr;
        ctrl_wdata   = data;
        ctrl_awvalid = 1'b1;
        ctrl_wvalid  = 1'b1;
        ctrl_bready  = 1'b0;
        n = 0;
        @(negedge aclk);
        while (!(ctrl_awready && ctrl_wready)) begin
            n++;
            if (n > LIMIT) abort_run("awready and wready never came");
            @(negedge aclk);
        end
        @(posedge aclk);
        #2;
        ctrl_awvalid = 1'b0;
        ctrl_wvalid  = 1'b0;
        n = 0;
        @(negedge aclk);
        while (!ctrl_bvalid) begin
            n++;
            if (n > LIMIT) abort_run("write response never came");
            @(negedge aclk);
        end
        check_equal(32'(ctrl_bresp), 32'(exp_resp), "bresp");
        // Response left waiting one cycle before bready
        @(posedge aclk);
        #2;
        ctrl_bready = 1'b1;
        @(posedge aclk);
        #2;
        ctrl_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output axi_resp_e resp);
        int n;
        ctrl_araddr  = addr;
        ctrl_arvalid = 1'b1;
        ctrl_rready  = 1'b1;
        n = 0;
        @(negedge aclk);
        while (!ctrl_arready) begin
            n++;
            if (n > LIMIT) abort_run("arready never came");
            @(negedge aclk);
        end
        @(posedge aclk);
        #2;
        ctrl_arvalid = 1'b0;
        n = 0;
        @(negedge aclk);
        while (!ctrl_rvalid) begin
            n++;
            if (n > LIMIT) abort_run("read data never came");
            @(negedge aclk);
        end
        data = ctrl_rdata;
        resp = ctrl_rresp;
        @(posedge aclk);
        #2;
        ctrl_rready = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h9c1a_2c16));
        errors = 0;
        checks = 0;
        tests  = 0;
        aclk = 1'b0;
        arst_n = 1'b0;
        tx_s_tdata = '0;
        tx_s_tdest = '0;
        tx_s_tkeep = '0;
        tx_s_tlast = 1'b0;
        tx_s_tvalid = 1'b0;
        tx_m_tready = 1'b0;
        ctrl_awaddr = '0;
        ctrl_awvalid = 1'b0;
        ctrl_wdata = '0;
        ctrl_wvalid = 1'b0;
        ctrl_bready = 1'b0;
        ctrl_araddr = '0;
        ctrl_arvalid = 1'b0;
        ctrl_rready = 1'b0;
        repeat (3) @(posedge aclk);
        #2;
        arst_n = 1'b1;

        // Random packets within the limit
        repeat (12) send_packet(1 + ($urandom % MAX_BEATS), 1'b0);
        wait_drained();
        finish_test("passthrough");

        // Oversize packet cut to the limit, then channel cut
        send_packet(11, 1'b0);
        wait_drained();
        axi_read(VERIFIER_REG_ADDR, rd_data, rd_resp);
        check_equal(rd_data, 32'd1 << OVERSIZE_IRQ_BIT, "oversize register");
        axi_read(DECOUPLE_REG_ADDR, rd_data, rd_resp);
        check_equal(rd_data, 32'd1 << DECOUPLED_STATUS_BIT, "decouple register");
        send_packet(4, 1'b1);
        wait_drained();
        finish_test("oversize truncation");

        // Clear pulse releases the error and the channel
        axi_write(VERIFIER_REG_ADDR, 32'd1 << OVERSIZE_CLEAR_BIT, RESP_OKAY);
        axi_write(VERIFIER_REG_ADDR, 32'd0, RESP_OKAY);
        axi_read(VERIFIER_REG_ADDR, rd_data, rd_resp);
        check_equal(rd_data, 32'd0, "oversize register after clear");
        send_packet(5, 1'b0);
        wait_drained();
        finish_test("error clear");

        // Decouple requested with a packet half sent
        build_packet(6);
        expected_beats(1'b0);
        send_beats(0, 2);
        axi_write(DECOUPLE_REG_ADDR, 32'd1 << DECOUPLE_BIT, RESP_OKAY);
        axi_read(DECOUPLE_REG_ADDR, rd_data, rd_resp);
        check_equal(rd_data, 32'd1 << DECOUPLE_BIT, "decouple register while draining");
        send_beats(3, 5);
        wait_drained();
        axi_read(DECOUPLE_REG_ADDR, rd_data, rd_resp);
        check_equal(rd_data, (32'd1 << DECOUPLE_BIT) | (32'd1 << DECOUPLE_DONE_BIT)
                    | (32'd1 << DECOUPLED_STATUS_BIT), "decouple register when done");
        send_packet(3, 1'b1);
        wait_drained();
        finish_test("mid-packet decouple");

        // Recouple, unmapped address, read-only bits
        axi_write(DECOUPLE_REG_ADDR, 32'd0, RESP_OKAY);
        send_packet(7, 1'b0);
        wait_drained();
        axi_read(32'd12, rd_data, rd_resp);
        check_equal(rd_data, 32'd0, "unmapped read data");
        check_equal(32'(rd_resp), 32'(RESP_SLVERR), "unmapped read response");
        axi_write(DECOUPLE_REG_ADDR, (32'd1 << DECOUPLE_DONE_BIT)
                  | (32'd1 << DECOUPLED_STATUS_BIT), RESP_OKAY);
        axi_read(DECOUPLE_REG_ADDR, rd_data, rd_resp);
        check_equal(rd_data, 32'd0, "decouple register status bits");
        axi_write(VERIFIER_REG_ADDR, 32'd1 << OVERSIZE_IRQ_BIT, RESP_OKAY);
        axi_read(VERIFIER_REG_ADDR, rd_data, rd_resp);
        check_equal(rd_data, 32'd0, "oversize register irq bit");
        finish_test("recouple and register rules");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/net_iso_pkg.sv
src/tx_decoupler.sv
src/tx_oversize_verifier.sv
src/reg_slice_full.sv
src/net_iso_reg_file.sv
src/net_iso_top.sv
verification/net_iso_assert.sv
verification/net_iso_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the egress isolation testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module net_iso_tb \
    -f filelist.f \
    -o net_iso_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/net_iso_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
